// File: rtl/xgmii_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII lane-group types and control character codes
// for the 32-bit interface, lane 0 in the low byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package xgmii_pkg;

    // lanes per group on the 32-bit interface
    localparam int XGMII_LANES = 4;

    // one group of four lanes, lane 0 in bits 7:0
    typedef logic [31:0] xgmii_data_t;

    // control flag per lane, bit i belongs to lane i
    typedef logic [3:0] xgmii_ctrl_t;

    // a single lane character
    typedef logic [7:0] xgmii_char_t;

    // control characters, valid only with the lane's control flag set
    localparam xgmii_char_t XGMII_IDLE  = 8'h07;
    localparam xgmii_char_t XGMII_START = 8'hfb;
    localparam xgmii_char_t XGMII_TERM  = 8'hfd;
    localparam xgmii_char_t XGMII_ERROR = 8'hfe;

endpackage

// File: rtl/eth_rx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive stream types, FCS constants and the
// statistics register map of the 10G receive MAC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package eth_rx_pkg;

    typedef logic [3:0]  byte_keep_t;
    typedef logic [31:0] crc_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // one stream beat, user is only meaningful with last
    typedef struct packed {
        xgmii_pkg::xgmii_data_t data;
        byte_keep_t             keep;
        logic                   valid;
        logic                   last;
        logic                   user;
    } rx_beat_t;

    // single-cycle error pulses, aligned with the last beat
    typedef struct packed {
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    // reflected CRC-32, no final inversion on the running state
    localparam crc_t CRC_POLY    = 32'hedb88320;
    localparam crc_t CRC_INIT    = 32'hffffffff;
    localparam crc_t CRC_RESIDUE = 32'hdebb20e3;

    // statistics registers
    localparam reg_addr_t STAT_FRAMES_OK  = 8'h00;
    localparam reg_addr_t STAT_FRAMES_BAD = 8'h04;
    localparam reg_addr_t STAT_FCS_ERR    = 8'h08;
    localparam reg_addr_t STAT_BYTES_OK   = 8'h0c;
    localparam reg_addr_t STAT_CTRL       = 8'h10;

    // writing 1 here clears every counter
    localparam int STAT_CTRL_CLEAR_BIT = 0;

endpackage

// File: rtl/crc32_step.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational CRC-32 update over DATA_BYTES bytes,
// byte 0 in the low bits, each byte LSB first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module crc32_step #(
    parameter int DATA_BYTES = 4
) (
    input  logic [DATA_BYTES*8-1:0] data_in,
    input  eth_rx_pkg::crc_t        state_in,
    output eth_rx_pkg::crc_t        state_out
);
    import eth_rx_pkg::*;

    // bitwise shift register, unrolled by the loop
    always_comb begin : crc_loop
        crc_t crc;

        crc = state_in;
        for (int i = 0; i < DATA_BYTES * 8; i++) begin
            if (crc[0] ^ data_in[i]) begin
                crc = (crc >> 1) ^ CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        state_out = crc;
    end

endmodule

// File: rtl/xgmii_rx_32.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII frame receiver, one lane group per clock
// strips start and preamble, checks the FCS and emits
// beats with keep, last and a bad-frame flag in user
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module xgmii_rx_32 (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  xgmii_pkg::xgmii_data_t xgmii_rxd,
    input  xgmii_pkg::xgmii_ctrl_t xgmii_rxc,
    output eth_rx_pkg::rx_beat_t   rx_beat,
    output eth_rx_pkg::rx_status_t rx_status
);
    import xgmii_pkg::*;
    import eth_rx_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_preamble,
        state_payload,
        state_last
    } rx_state_e;

    // decode of one word, travels down the delay line with it
    typedef struct packed {
        logic       start;
        logic       term;
        logic       bad;
        logic       fcs_ok;
        byte_keep_t keep;
    } word_info_t;

    rx_state_e state;
    rx_state_e state_next;

    xgmii_data_t rxd_d0;
    xgmii_data_t rxd_d1;
    xgmii_data_t rxd_d2;
    xgmii_ctrl_t rxc_d0;

    word_info_t info_d0;
    word_info_t info_d1;
    word_info_t info_d2;

    logic [XGMII_LANES-1:0] term_lanes;

    crc_t                   crc_state;
    crc_t                   crc_next [XGMII_LANES];
    logic [XGMII_LANES-1:0] crc_ok;
    logic                   crc_ok_full_save;
    logic                   crc_clear;

    rx_beat_t   beat_next;
    rx_status_t status_next;

    // input delay line, d0 newest
    always_ff @(posedge clk) begin
        rxd_d0 <= xgmii_rxd;
        rxd_d1 <= rxd_d0;
        rxd_d2 <= rxd_d1;
        if (reset_crc) begin
            rxc_d0  <= '0;
            info_d1 <= '0;
            info_d2 <= '0;
        end else begin
            rxc_d0  <= xgmii_rxc;
            info_d1 <= info_d0;
            info_d2 <= info_d1;
        end
    end

    always_comb begin
        for (int i = 0; i < XGMII_LANES; i++) begin
            term_lanes[i] = rxc_d0[i] && (rxd_d0[8*i +: 8] == XGMII_TERM);
        end
    end

    // first terminate lane sets the keep mask and picks the FCS result
    always_comb begin
        info_d0       = '0;
        info_d0.start = rxc_d0[0] && (rxd_d0[7:0] == XGMII_START);
        info_d0.term  = |term_lanes;
        casez (term_lanes)
            4'b???1: begin
                // FCS ended with the previous full word
                info_d0.keep   = 4'b0000;
                info_d0.fcs_ok = crc_ok_full_save;
            end
            4'b??10: begin
                info_d0.keep   = 4'b0001;
                info_d0.fcs_ok = crc_ok[0];
            end
            4'b?100: begin
                info_d0.keep   = 4'b0011;
                info_d0.fcs_ok = crc_ok[1];
            end
            4'b1000: begin
                info_d0.keep   = 4'b0111;
                info_d0.fcs_ok = crc_ok[2];
            end
            default: begin
                info_d0.keep   = 4'b1111;
                info_d0.fcs_ok = 1'b0;
            end
        endcase
        // any control character ahead of the terminate breaks the frame
        info_d0.bad = |(rxc_d0 & info_d0.keep);
    end

    // one CRC step per possible end-of-frame width
    for (genvar g = 0; g < XGMII_LANES; g++) begin : g_crc
        crc32_step #(
            .DATA_BYTES(g + 1)
        ) i_crc (
            .data_in  (rxd_d0[8*(g+1)-1:0]),
            .state_in (crc_state),
            .state_out(crc_next[g])
        );

        assign crc_ok[g] = (crc_next[g] == CRC_RESIDUE);
    end

    // restart while the start and preamble words sit in d0
    assign crc_clear = info_d0.start || info_d1.start;

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_state        <= CRC_INIT;
            crc_ok_full_save <= 1'b0;
        end else begin
            crc_state        <= crc_next[XGMII_LANES-1];
            crc_ok_full_save <= crc_ok[XGMII_LANES-1];
        end
    end

    // FSM works on d2 and looks one word ahead at d1
    always_comb begin
        state_next     = state;
        beat_next      = '0;
        beat_next.data = rxd_d2;
        beat_next.keep = '1;
        status_next    = '0;

        case (state)
            state_idle: begin
                if (info_d2.start) begin
                    state_next = state_preamble;
                end
            end
            state_preamble: begin
                // preamble and SFD word is dropped
                if (info_d1.term) begin
                    state_next = state_last;
                end else begin
                    state_next = state_payload;
                end
            end
            state_payload: begin
                beat_next.valid = 1'b1;
                if (info_d2.bad) begin
                    beat_next.last        = 1'b1;
                    beat_next.user        = 1'b1;
                    status_next.bad_frame = 1'b1;
                    state_next            = state_idle;
                end else if (info_d1.term && info_d1.keep == '0) begin
                    // terminate in lane 0 of the next word
                    beat_next.last        = 1'b1;
                    beat_next.user        = !info_d1.fcs_ok;
                    status_next.bad_frame = !info_d1.fcs_ok;
                    status_next.bad_fcs   = !info_d1.fcs_ok;
                    state_next            = state_idle;
                end else if (info_d1.term) begin
                    state_next = state_last;
                end
            end
            state_last: begin
                beat_next.valid = 1'b1;
                beat_next.last  = 1'b1;
                beat_next.keep  = info_d2.keep;
                if (info_d2.bad) begin
                    beat_next.user        = 1'b1;
                    status_next.bad_frame = 1'b1;
                end else if (!info_d2.fcs_ok) begin
                    beat_next.user        = 1'b1;
                    status_next.bad_frame = 1'b1;
                    status_next.bad_fcs   = 1'b1;
                end
                state_next = state_idle;
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        rx_beat <= beat_next;
        if (reset_crc) begin
            state         <= state_idle;
            rx_beat.valid <= 1'b0;
            rx_beat.last  <= 1'b0;
            rx_beat.user  <= 1'b0;
            rx_status     <= '0;
        end else begin
            state     <= state_next;
            rx_status <= status_next;
        end
    end

endmodule

// File: rtl/rx_stats_apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturating frame, error and byte counters of the
// receive stream, read and cleared over APB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rx_stats_apb #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  eth_rx_pkg::rx_beat_t   rx_beat,
    input  eth_rx_pkg::rx_status_t rx_status,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  eth_rx_pkg::reg_addr_t  paddr,
    input  eth_rx_pkg::reg_data_t  pwdata,
    output eth_rx_pkg::reg_data_t  prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import eth_rx_pkg::*;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    count_t     frames_ok;
    count_t     frames_bad;
    count_t     fcs_err;
    count_t     bytes_ok;
    count_t     frame_bytes;
    count_t     frame_total;
    logic [2:0] beat_bytes;
    logic       addr_hit;
    logic       clear_req;

    // sticks at all ones instead of wrapping
    function automatic count_t sat_add(count_t a, count_t b);
        logic [COUNT_WIDTH:0] sum;

        sum = {1'b0, a} + {1'b0, b};
        return sum[COUNT_WIDTH] ? '1 : sum[COUNT_WIDTH-1:0];
    endfunction

    assign beat_bytes  = 3'($countones(rx_beat.keep));
    assign frame_total = sat_add(frame_bytes, count_t'(beat_bytes));

    // running byte count of the frame in flight
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            frame_bytes <= '0;
        end else if (rx_beat.valid) begin
            frame_bytes <= rx_beat.last ? '0 : frame_total;
        end
    end

    assign clear_req = psel && penable && pwrite && (paddr == STAT_CTRL)
                       && pwdata[STAT_CTRL_CLEAR_BIT];

    always_ff @(posedge clk) begin
        if (reset_crc || clear_req) begin
            frames_ok  <= '0;
            frames_bad <= '0;
            fcs_err    <= '0;
            bytes_ok   <= '0;
        end else if (rx_beat.valid && rx_beat.last) begin
            if (!rx_beat.user) begin
                frames_ok <= sat_add(frames_ok, count_t'(1));
                bytes_ok  <= sat_add(bytes_ok, frame_total);
            end else begin
                frames_bad <= sat_add(frames_bad, count_t'(1));
                if (rx_status.bad_fcs) begin
                    fcs_err <= sat_add(fcs_err, count_t'(1));
                end
            end
        end
    end

    // read mux, zero wait states
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            STAT_FRAMES_OK:  prdata = reg_data_t'(frames_ok);
            STAT_FRAMES_BAD: prdata = reg_data_t'(frames_bad);
            STAT_FCS_ERR:    prdata = reg_data_t'(fcs_err);
            STAT_BYTES_OK:   prdata = reg_data_t'(bytes_ok);
            STAT_CTRL:       prdata = '0;
            default:         addr_hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = psel && penable && !addr_hit;

endmodule

// File: rtl/eth_rx_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10G Ethernet receive MAC top level
// XGMII in, beat stream and status out, APB counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module eth_rx_top #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  xgmii_pkg::xgmii_data_t xgmii_rxd,
    input  xgmii_pkg::xgmii_ctrl_t xgmii_rxc,
    output eth_rx_pkg::rx_beat_t   rx_beat,
    output eth_rx_pkg::rx_status_t rx_status,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  eth_rx_pkg::reg_addr_t  paddr,
    input  eth_rx_pkg::reg_data_t  pwdata,
    output eth_rx_pkg::reg_data_t  prdata,
    output logic                   pready,
    output logic                   pslverr
);

    xgmii_rx_32 i_rx (
        .clk      (clk),
        .reset_crc(reset_crc),
        .xgmii_rxd(xgmii_rxd),
        .xgmii_rxc(xgmii_rxc),
        .rx_beat  (rx_beat),
        .rx_status(rx_status)
    );

    // counters watch the same stream that leaves the top level
    rx_stats_apb #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) i_stats (
        .clk      (clk),
        .reset_crc(reset_crc),
        .rx_beat  (rx_beat),
        .rx_status(rx_status),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

endmodule

// File: bench/eth_rx_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks on the receiver's beat and status
// outputs, bound into every xgmii_rx_32 instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module eth_rx_assertions (
    input logic                   clk,
    input logic                   reset_crc,
    input eth_rx_pkg::rx_beat_t   rx_beat,
    input eth_rx_pkg::rx_status_t rx_status
);
    import eth_rx_pkg::*;

    // an FCS error is always reported as a bad frame too
    fcs_implies_bad: assert property (@(posedge clk) disable iff (reset_crc)
        rx_status.bad_fcs |-> rx_status.bad_frame)
        else $error("bad_fcs pulsed without bad_frame");

    // status pulses ride on the flagged last beat
    bad_on_last_beat: assert property (@(posedge clk) disable iff (reset_crc)
        rx_status.bad_frame |-> rx_beat.valid && rx_beat.last && rx_beat.user)
        else $error("bad_frame pulsed outside a flagged last beat");

    // only the last beat may be partial
    full_keep_mid_frame: assert property (@(posedge clk) disable iff (reset_crc)
        rx_beat.valid && !rx_beat.last |-> rx_beat.keep == byte_keep_t'('1))
        else $error("partial keep on a beat that is not last");

    quiet_in_reset: assert property (@(posedge clk)
        reset_crc |=> !rx_beat.valid)
        else $error("valid high while in reset");

endmodule

// File: bench/tb_eth_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the 10G receive MAC: builds
// XGMII frames, scores the beat stream, reads the APB
// counters; run from the project root with list.f
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_eth_rx;
    import xgmii_pkg::*;
    import eth_rx_pkg::*;

    localparam int          COUNT_WIDTH = 32;
    localparam logic [31:0] SEED        = 32'hf426c7b2;
    // eight frames of at most 21 words plus gaps and about 40 APB cycles
    // come to roughly 350 cycles, so this leaves a wide margin
    localparam int          MAX_CYCLES  = 4000;

    typedef struct packed {
        xgmii_data_t data;
        byte_keep_t  keep;
        logic        last;
        logic        user;
        logic        bad_fcs;
    } exp_beat_t;

    logic        clk = 1'b0;
    logic        reset_crc;
    xgmii_data_t xgmii_rxd;
    xgmii_ctrl_t xgmii_rxc;
    rx_beat_t    rx_beat;
    rx_status_t  rx_status;
    logic        psel;
    logic        penable;
    logic        pwrite;
    reg_addr_t   paddr;
    reg_data_t   pwdata;
    reg_data_t   prdata;
    logic        pready;
    logic        pslverr;

    exp_beat_t exp_q[$];
    int        cycle_count = 0;
    int        check_count = 0;
    int        err_count   = 0;
    int        test_count  = 0;
    int        exp_ok      = 0;
    int        exp_bad     = 0;
    int        exp_fcs     = 0;
    int        exp_bytes   = 0;

    eth_rx_top #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) i_dut (
        .clk      (clk),
        .reset_crc(reset_crc),
        .xgmii_rxd(xgmii_rxd),
        .xgmii_rxc(xgmii_rxc),
        .rx_beat  (rx_beat),
        .rx_status(rx_status),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    bind xgmii_rx_32 eth_rx_assertions i_assertions (
        .clk      (clk),
        .reset_crc(reset_crc),
        .rx_beat  (rx_beat),
        .rx_status(rx_status)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            err_count++;
        end
    endtask

    function automatic logic [31:0] lane_mask(input byte_keep_t keep);
        logic [31:0] m;

        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    // Ethernet FCS: reflected CRC-32, byte at a time, inverted at the end
    function automatic logic [31:0] fcs_of(input logic [7:0] data[$]);
        logic [31:0] c;

        c = 32'hffffffff;
        foreach (data[k]) begin
            c = c ^ {24'h0, data[k]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // scoreboard, sampled mid-cycle where the outputs are stable
    always @(negedge clk) begin : monitor
        exp_beat_t   e;
        logic [31:0] mask;

        if (cycle_count > 0) begin
            if (rx_beat.valid === 1'b1) begin
                check_count++;
                assert (exp_q.size() > 0) else begin
                    $display("beat arrived with no frame outstanding, data %h", rx_beat.data);
                    err_count++;
                end
                if (exp_q.size() > 0) begin
                    e    = exp_q.pop_front();
                    mask = lane_mask(e.keep);
                    compare_value("rx_beat.data", rx_beat.data & mask, e.data & mask);
                    compare_value("rx_beat.keep", 32'(rx_beat.keep), 32'(e.keep));
                    compare_value("rx_beat.last", 32'(rx_beat.last), 32'(e.last));
                    compare_value("rx_beat.user", 32'(rx_beat.user), 32'(e.user));
                    compare_value("rx_status.bad_frame", 32'(rx_status.bad_frame),
                                  32'(e.last && e.user));
                    compare_value("rx_status.bad_fcs", 32'(rx_status.bad_fcs),
                                  32'(e.bad_fcs));
                end
            end else begin
                compare_value("rx_beat.valid", 32'(rx_beat.valid), 32'h0);
                compare_value("rx_status.bad_frame", 32'(rx_status.bad_frame), 32'h0);
                compare_value("rx_status.bad_fcs", 32'(rx_status.bad_fcs), 32'h0);
            end
        end
    end

    task automatic drive_word(input xgmii_data_t d, input xgmii_ctrl_t c);
        @(posedge clk);
        #2;
        xgmii_rxd = d;
        xgmii_rxc = c;
    endtask

    task automatic send_idle(input int n);
        repeat (n) begin
            drive_word({4{XGMII_IDLE}}, 4'hf);
        end
    endtask

    // err_pos below zero means no error character in the payload
    task automatic send_frame(input int len, input logic flip_fcs, input int err_pos);
        logic [7:0]  body[$];
        logic [7:0]  lane_d[$];
        logic        lane_c[$];
        logic [31:0] fcs;
        exp_beat_t   e;
        int          nbytes;
        int          nwords;

        for (int i = 0; i < len; i++) begin
            body.push_back(8'($urandom));
        end
        fcs = fcs_of(body);
        if (flip_fcs) begin
            fcs[5] = ~fcs[5];
        end
        for (int i = 0; i < 4; i++) begin
            body.push_back(fcs[8*i +: 8]);
        end
        if (err_pos >= 0) begin
            body[err_pos] = XGMII_ERROR;
        end
        nbytes = body.size();

        // wire order: start, six preamble bytes, SFD, body, terminate, idle fill
        lane_d.push_back(XGMII_START);
        lane_c.push_back(1'b1);
        for (int i = 0; i < 7; i++) begin
            lane_d.push_back(i == 6 ? 8'hd5 : 8'h55);
            lane_c.push_back(1'b0);
        end
        foreach (body[i]) begin
            lane_d.push_back(body[i]);
            lane_c.push_back(i == err_pos);
        end
        lane_d.push_back(XGMII_TERM);
        lane_c.push_back(1'b1);
        while (lane_d.size() % 4 != 0) begin
            lane_d.push_back(XGMII_IDLE);
            lane_c.push_back(1'b1);
        end

        // an error character cuts the frame at its word
        nwords = (err_pos >= 0) ? err_pos / 4 + 1 : (nbytes + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            e = '0;
            for (int i = 0; i < 4; i++) begin
                if (4*w + i < nbytes) begin
                    e.data[8*i +: 8] = body[4*w + i];
                    e.keep[i]        = 1'b1;
                end
            end
            if (w == nwords - 1) begin
                e.last    = 1'b1;
                e.user    = flip_fcs || (err_pos >= 0);
                e.bad_fcs = flip_fcs && (err_pos < 0);
            end
            exp_q.push_back(e);
        end

        if (flip_fcs || err_pos >= 0) begin
            exp_bad++;
            if (err_pos < 0) begin
                exp_fcs++;
            end
        end else begin
            exp_ok++;
            exp_bytes += nbytes;
        end

        for (int w = 0; w < lane_d.size() / 4; w++) begin
            drive_word({lane_d[4*w+3], lane_d[4*w+2], lane_d[4*w+1], lane_d[4*w]},
                       {lane_c[4*w+3], lane_c[4*w+2], lane_c[4*w+1], lane_c[4*w]});
        end
    endtask

    // idle until every expected beat is out, then a few quiet cycles
    task automatic drain_expected();
        while (exp_q.size() > 0) begin
            send_idle(1);
        end
        send_idle(4);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // zero wait states, so the access phase completes in one cycle
        @(negedge clk);
        compare_value("pready", 32'(pready), 32'h1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        compare_value("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic expect_reg(input reg_addr_t addr, input string name, input int exp);
        reg_data_t d;
        logic      err;

        read_reg(addr, d, err);
        compare_value(name, d, exp);
        compare_value("pslverr", 32'(err), 32'h0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // runs first, so it also covers the cycles right after reset
    task automatic quiet_bus();
        int errs;

        errs = err_count;
        send_idle(3);
        drive_word({XGMII_IDLE, XGMII_IDLE, XGMII_IDLE, XGMII_TERM}, 4'hf);
        drive_word({4{XGMII_ERROR}}, 4'hf);
        drive_word({XGMII_IDLE, XGMII_ERROR, XGMII_TERM, XGMII_IDLE}, 4'hf);
        drive_word(32'h5555_55d5, 4'h0);
        drive_word({XGMII_TERM, 8'h12, 8'h34, 8'h56}, 4'h8);
        send_idle(8);
        report_test("quiet_bus", errs);
    endtask

    // 60 to 63 byte payloads walk the terminate through all four lanes
    task automatic good_frame_lengths();
        int errs;

        errs = err_count;
        for (int len = 60; len < 64; len++) begin
            send_idle(2);
            send_frame(len, 1'b0, -1);
        end
        drain_expected();
        report_test("good_frame_lengths", errs);
    endtask

    task automatic corrupt_fcs();
        int errs;

        errs = err_count;
        send_idle(2);
        send_frame(64, 1'b1, -1);
        drain_expected();
        report_test("corrupt_fcs", errs);
    endtask

    task automatic error_mid_payload();
        int errs;

        errs = err_count;
        send_idle(2);
        send_frame(64, 1'b0, 30);
        drain_expected();
        report_test("error_mid_payload", errs);
    endtask

    task automatic back_to_back();
        int errs;

        errs = err_count;
        send_idle(2);
        send_frame(60, 1'b0, -1);
        send_frame(62, 1'b0, -1);
        drain_expected();
        report_test("back_to_back", errs);
    endtask

    task automatic register_readback();
        int        errs;
        reg_data_t d;
        logic      err;

        errs = err_count;
        expect_reg(STAT_FRAMES_OK, "frames_ok", exp_ok);
        expect_reg(STAT_FRAMES_BAD, "frames_bad", exp_bad);
        expect_reg(STAT_FCS_ERR, "fcs_err", exp_fcs);
        expect_reg(STAT_BYTES_OK, "bytes_ok", exp_bytes);
        read_reg(8'h14, d, err);
        compare_value("pslverr", 32'(err), 32'h1);
        write_reg(STAT_CTRL, 32'h1);
        expect_reg(STAT_FRAMES_OK, "frames_ok", 0);
        expect_reg(STAT_FRAMES_BAD, "frames_bad", 0);
        expect_reg(STAT_FCS_ERR, "fcs_err", 0);
        expect_reg(STAT_BYTES_OK, "bytes_ok", 0);
        report_test("register_readback", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        reset_crc = 1'b1;
        xgmii_rxd = {4{XGMII_IDLE}};
        xgmii_rxc = 4'hf;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (16) @(posedge clk);
        #2;
        reset_crc = 1'b0;

        quiet_bus();
        good_frame_lengths();
        corrupt_fcs();
        error_mid_payload();
        back_to_back();
        register_readback();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/xgmii_pkg.sv
rtl/eth_rx_pkg.sv
rtl/crc32_step.sv
rtl/xgmii_rx_32.sv
rtl/rx_stats_apb.sv
rtl/eth_rx_top.sv
bench/eth_rx_assertions.sv
bench/tb_eth_rx.sv

// File: Makefile
# Verilator build and run of the 10G receive MAC testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_rx
RTL_TOP   ?= eth_rx_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
